// ==== lcd_bus_pkg.sv ====
/*
 * HD44780 bus definitions
 * Command codes, the settle class sent with each byte and the
 * two decodings of one bus byte
 */

package lcd_bus_pkg;

    // ==================================================
    // Command codes
    // ==================================================
    localparam logic [7:0] CMD_FUNC_SET_8BIT = 8'h30; // Wake-up function set
    localparam logic [7:0] CMD_FUNC_SET      = 8'h38; // 8-bit bus, 2 lines, 5x8
    localparam logic [7:0] CMD_DISPLAY_OFF   = 8'h08;
    localparam logic [7:0] CMD_CLEAR         = 8'h01;
    localparam logic [7:0] CMD_ENTRY_MODE    = 8'h06; // Increment, no shift
    localparam logic [7:0] CMD_DISPLAY_ON    = 8'h0C; // Cursor and blink off

    // DDRAM address where line 2 starts
    localparam logic [6:0] DDRAM_LINE2_BASE = 7'h40;

    localparam int INIT_LEN = 8; // Commands in the power-on list

    // ==================================================
    // Settle class per byte
    // ==================================================
    typedef enum logic [1:0] {
        DLY_CMD,   // Plain command or character
        DLY_WAKE,  // Long wait after first wake-up
        DLY_CLEAR  // Clear needs the longest settle
    } lcd_dly_e;

    // ==================================================
    // Bus byte, raw or as set-address command
    // ==================================================
    typedef union packed {
        logic [7:0] raw;       // Command code or character
        struct packed {
            logic       set_addr; // Always 1 for set-DDRAM-address
            logic       line;     // Address bit 6 selects line 2
            logic [5:0] col;
        } ddram;
    } lcd_byte_u;

endpackage

// ==== lcd_text_pkg.sv ====
/*
 * String interface geometry
 * Line width, character width and position types of the text ports
 */

package lcd_text_pkg;

    localparam int CHARS_PER_LINE = 16;
    localparam int CHAR_W         = 8;                      // One ASCII code
    localparam int LINE_W         = CHARS_PER_LINE * CHAR_W; // 128 bits per line

    // Character position inside a line, 0 is leftmost
    typedef logic [3:0] char_idx_t;

    // Panel row being written
    typedef enum logic {
        LINE_1,
        LINE_2
    } line_sel_e;

endpackage

// ==== lcd_text_buffer.sv ====
/*
 * Text buffer
 * Captures both display lines on load and returns the character
 * that the sequencer points at
 */

module lcd_text_buffer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load,
    input  logic [lcd_text_pkg::LINE_W-1:0]   line1_data,
    input  logic [lcd_text_pkg::LINE_W-1:0]   line2_data,
    input  lcd_text_pkg::line_sel_e           line_sel,
    input  lcd_text_pkg::char_idx_t           char_idx,
    output logic [lcd_text_pkg::CHAR_W-1:0]   cur_char
);

    import lcd_text_pkg::*;

    // Byte-indexed copies of the two lines
    logic [CHARS_PER_LINE-1:0][CHAR_W-1:0] line1_q;
    logic [CHARS_PER_LINE-1:0][CHAR_W-1:0] line2_q;

    char_idx_t pos; // Array slot of the selected character

    // ==================================================
    // Line capture
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line1_q <= '0;
            line2_q <= '0;
        end else if (load) begin
            line1_q <= line1_data; // Snapshot, inputs free afterwards
            line2_q <= line2_data;
        end
    end

    // ==================================================
    // Character select
    // ==================================================
    // Position 0 sits in the top byte of the port
    assign pos = char_idx_t'(CHARS_PER_LINE - 1) - char_idx;

    always_comb begin
        if (line_sel == LINE_2) begin
            cur_char = line2_q[pos];
        end else begin
            cur_char = line1_q[pos];
        end
    end

endmodule

// ==== lcd_sequencer.sv ====
/*
 * LCD sequencer
 * Sends the power-on command list, then writes both lines on each
 * accepted update. Every byte goes out through the bus driver
 */

module lcd_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             update_display,
    input  logic [lcd_text_pkg::CHAR_W-1:0]  cur_char,
    input  logic                             drv_ready,
    input  logic                             drv_busy,
    output logic                             load,
    output lcd_text_pkg::line_sel_e          line_sel,
    output lcd_text_pkg::char_idx_t          char_idx,
    output logic                             send,
    output lcd_bus_pkg::lcd_byte_u           cmd_byte,
    output logic                             is_data,
    output lcd_bus_pkg::lcd_dly_e            dly,
    output logic                             ready,
    output logic                             busy
);

    import lcd_bus_pkg::*;
    import lcd_text_pkg::*;

    localparam int IDX_W = $clog2(INIT_LEN);

    // Power-on list, entry 0 in the low byte
    localparam logic [INIT_LEN-1:0][7:0] INIT_CMDS = {
        CMD_DISPLAY_ON,
        CMD_ENTRY_MODE,
        CMD_CLEAR,
        CMD_DISPLAY_OFF,
        CMD_FUNC_SET,
        CMD_FUNC_SET_8BIT,
        CMD_FUNC_SET_8BIT,
        CMD_FUNC_SET_8BIT
    };

    typedef enum logic [2:0] {
        S_PWRUP,      // Driver still in power-up wait
        S_INIT,       // Issue next power-on command
        S_IDLE,
        S_SET_ADDR,   // Set-address for the current line
        S_WRITE_CHAR,
        S_WAIT_DRV    // Byte in flight
    } state_e;

    state_e          state;
    state_e          ret_state; // Where to go once the driver is free
    logic [IDX_W-1:0] init_idx;

    logic [6:0] ddram_addr;
    lcd_byte_u  addr_byte;
    lcd_byte_u  char_byte;
    lcd_byte_u  init_byte;

    // Settle class of a power-on entry
    function automatic lcd_dly_e init_dly(input logic [IDX_W-1:0] idx);
        if (idx == '0) begin
            return DLY_WAKE;              // First wake-up needs >4.1 ms
        end else if (INIT_CMDS[idx] == CMD_CLEAR) begin
            return DLY_CLEAR;
        end
        return DLY_CMD;
    endfunction

    // ==================================================
    // Byte composition
    // ==================================================
    always_comb begin
        ddram_addr = (line_sel == LINE_2) ? DDRAM_LINE2_BASE : 7'h00;
        addr_byte.ddram.set_addr = 1'b1;
        addr_byte.ddram.line     = ddram_addr[6];
        addr_byte.ddram.col      = ddram_addr[5:0]; // Always column 0
        char_byte.raw = cur_char;
        init_byte.raw = INIT_CMDS[init_idx];
    end

    assign ready = (state == S_IDLE) && !drv_busy;
    assign busy  = !ready;
    assign load  = ready && update_display; // Only the accept cycle counts

    // ==================================================
    // Main FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_PWRUP;
            ret_state <= S_IDLE;
            init_idx  <= '0;
            line_sel  <= LINE_1;
            char_idx  <= '0;
            send      <= 1'b0;
            cmd_byte  <= '0;
            is_data   <= 1'b0;
            dly       <= DLY_CMD;
        end else begin
            send <= 1'b0; // Single-cycle strobe
            case (state)
                S_PWRUP: begin
                    if (drv_ready) state <= S_INIT;
                end
                S_INIT: begin
                    if (drv_ready && !drv_busy) begin
                        cmd_byte  <= init_byte;
                        is_data   <= 1'b0;
                        dly       <= init_dly(init_idx);
                        send      <= 1'b1;
                        init_idx  <= init_idx + 1'b1;
                        ret_state <= (init_idx == IDX_W'(INIT_LEN - 1)) ? S_IDLE : S_INIT;
                        state     <= S_WAIT_DRV;
                    end
                end
                S_IDLE: begin
                    if (load) begin
                        line_sel <= LINE_1;
                        state    <= S_SET_ADDR;
                    end
                end
                S_SET_ADDR: begin
                    if (!drv_busy) begin
                        cmd_byte  <= addr_byte;   // 80 or C0
                        is_data   <= 1'b0;
                        dly       <= DLY_CMD;
                        send      <= 1'b1;
                        char_idx  <= '0;
                        ret_state <= S_WRITE_CHAR;
                        state     <= S_WAIT_DRV;
                    end
                end
                S_WRITE_CHAR: begin
                    if (!drv_busy) begin
                        cmd_byte <= char_byte;
                        is_data  <= 1'b1;         // RS high for DDRAM data
                        dly      <= DLY_CMD;
                        send     <= 1'b1;
                        state    <= S_WAIT_DRV;
                        if (char_idx != char_idx_t'(CHARS_PER_LINE - 1)) begin
                            char_idx  <= char_idx + 1'b1;
                            ret_state <= S_WRITE_CHAR;
                        end else if (line_sel == LINE_1) begin
                            line_sel  <= LINE_2;   // Move on to second row
                            ret_state <= S_SET_ADDR;
                        end else begin
                            ret_state <= S_IDLE;
                        end
                    end
                end
                S_WAIT_DRV: begin
                    // Busy shows one cycle after send, so skip that cycle
                    if (!send && !drv_busy) state <= ret_state;
                end
                default: state <= S_PWRUP;
            endcase
        end
    end

endmodule

// ==== lcd_bus_driver.sv ====
/*
 * LCD bus driver
 * Power-up wait, then per byte: setup, enable pulse and settle time
 * on the HD44780 pins, all from one down-counter
 */

module lcd_bus_driver #(
    parameter int unsigned PWRUP_CYC     = 2_000_000,
    parameter int unsigned EN_SETUP      = 2,
    parameter int unsigned EN_HIGH       = 25,
    parameter int unsigned DLY_CMD_CYC   = 10_000,
    parameter int unsigned DLY_WAKE_CYC  = 250_000,
    parameter int unsigned DLY_CLEAR_CYC = 150_000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    send,
    input  lcd_bus_pkg::lcd_byte_u  cmd_byte,
    input  logic                    is_data,
    input  lcd_bus_pkg::lcd_dly_e   dly,
    output logic                    drv_ready,
    output logic                    drv_busy,
    output logic                    LCD_ON,
    output logic                    LCD_BLON,
    output logic                    LCD_EN,
    output logic                    LCD_RS,
    output logic                    LCD_RW,
    output logic [7:0]              LCD_DATA
);

    import lcd_bus_pkg::*;

    typedef enum logic [2:0] {
        P_PWRUP,   // Panel supply settling
        P_IDLE,
        P_SETUP,   // RS/DATA valid, EN low
        P_EN_HIGH,
        P_SETTLE   // Panel executing the command
    } phase_e;

    phase_e      phase;
    logic [31:0] cnt;   // Shared by every phase
    lcd_dly_e    dly_q; // Class of the byte in flight
    logic        en_q;
    logic        rs_q;
    logic [7:0]  data_q;

    // Settle length of a class
    function automatic logic [31:0] settle_cyc(input lcd_dly_e d);
        case (d)
            DLY_WAKE:  return 32'(DLY_WAKE_CYC);
            DLY_CLEAR: return 32'(DLY_CLEAR_CYC);
            default:   return 32'(DLY_CMD_CYC);
        endcase
    endfunction

    // ==================================================
    // Phase sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= P_PWRUP;
            cnt    <= 32'(PWRUP_CYC - 1);
            dly_q  <= DLY_CMD;
            en_q   <= 1'b0;
            rs_q   <= 1'b0;
            data_q <= 8'h00;
        end else begin
            case (phase)
                P_PWRUP: begin
                    if (cnt == '0) phase <= P_IDLE;
                    else           cnt   <= cnt - 32'd1;
                end
                P_IDLE: begin
                    if (send) begin
                        rs_q   <= is_data;
                        data_q <= cmd_byte.raw;  // Held until next send
                        dly_q  <= dly;
                        cnt    <= 32'(EN_SETUP - 1);
                        phase  <= P_SETUP;
                    end
                end
                P_SETUP: begin
                    if (cnt == '0) begin
                        en_q  <= 1'b1;
                        cnt   <= 32'(EN_HIGH - 1);
                        phase <= P_EN_HIGH;
                    end else begin
                        cnt <= cnt - 32'd1;
                    end
                end
                P_EN_HIGH: begin
                    if (cnt == '0) begin
                        en_q  <= 1'b0;           // Panel latches on this edge
                        cnt   <= settle_cyc(dly_q) - 32'd1;
                        phase <= P_SETTLE;
                    end else begin
                        cnt <= cnt - 32'd1;
                    end
                end
                P_SETTLE: begin
                    if (cnt == '0) phase <= P_IDLE;
                    else           cnt   <= cnt - 32'd1;
                end
                default: phase <= P_IDLE;
            endcase
        end
    end

    assign drv_ready = (phase != P_PWRUP);
    assign drv_busy  = (phase != P_IDLE);

    // Panel pins, write-only bus
    assign LCD_ON   = 1'b1;
    assign LCD_BLON = 1'b1;
    assign LCD_RW   = 1'b0;
    assign LCD_EN   = en_q;
    assign LCD_RS   = rs_q;
    assign LCD_DATA = data_q;

endmodule

// ==== lcd_top.sv ====
/*
 * Character LCD controller top
 * Text buffer, sequencer and bus driver for a 2x16 HD44780 panel
 */

module lcd_top #(
    parameter int unsigned PWRUP_CYC     = 2_000_000, // 40 ms at 50 MHz
    parameter int unsigned EN_SETUP      = 2,
    parameter int unsigned EN_HIGH       = 25,        // 500 ns
    parameter int unsigned DLY_CMD_CYC   = 10_000,    // 200 us
    parameter int unsigned DLY_WAKE_CYC  = 250_000,   // 5 ms
    parameter int unsigned DLY_CLEAR_CYC = 150_000    // 3 ms
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [lcd_text_pkg::LINE_W-1:0] line1_data,
    input  logic [lcd_text_pkg::LINE_W-1:0] line2_data,
    input  logic                            update_display,
    output logic                            LCD_ON,
    output logic                            LCD_BLON,
    output logic                            LCD_EN,
    output logic                            LCD_RS,
    output logic                            LCD_RW,
    output logic [7:0]                      LCD_DATA,
    output logic                            ready,
    output logic                            busy
);

    import lcd_bus_pkg::*;
    import lcd_text_pkg::*;

    // Sequencer and buffer
    logic              load;
    line_sel_e         line_sel;
    char_idx_t         char_idx;
    logic [CHAR_W-1:0] cur_char;

    // Sequencer and driver
    logic      send;
    lcd_byte_u cmd_byte;
    logic      is_data;
    lcd_dly_e  dly;
    logic      drv_ready;
    logic      drv_busy;

    lcd_text_buffer u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .line1_data (line1_data),
        .line2_data (line2_data),
        .line_sel   (line_sel),
        .char_idx   (char_idx),
        .cur_char   (cur_char)
    );

    lcd_sequencer u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_display (update_display),
        .cur_char       (cur_char),
        .drv_ready      (drv_ready),
        .drv_busy       (drv_busy),
        .load           (load),
        .line_sel       (line_sel),
        .char_idx       (char_idx),
        .send           (send),
        .cmd_byte       (cmd_byte),
        .is_data        (is_data),
        .dly            (dly),
        .ready          (ready),
        .busy           (busy)
    );

    lcd_bus_driver #(
        .PWRUP_CYC     (PWRUP_CYC),
        .EN_SETUP      (EN_SETUP),
        .EN_HIGH       (EN_HIGH),
        .DLY_CMD_CYC   (DLY_CMD_CYC),
        .DLY_WAKE_CYC  (DLY_WAKE_CYC),
        .DLY_CLEAR_CYC (DLY_CLEAR_CYC)
    ) u_drv (
        .clk       (clk),
        .rst_n     (rst_n),
        .send      (send),
        .cmd_byte  (cmd_byte),
        .is_data   (is_data),
        .dly       (dly),
        .drv_ready (drv_ready),
        .drv_busy  (drv_busy),
        .LCD_ON    (LCD_ON),
        .LCD_BLON  (LCD_BLON),
        .LCD_EN    (LCD_EN),
        .LCD_RS    (LCD_RS),
        .LCD_RW    (LCD_RW),
        .LCD_DATA  (LCD_DATA)
    );

endmodule

// ==== lcd_assert.sv ====
/*
 * LCD bus protocol assertions
 * Bound into the bus driver, checks enable width, bus stability
 * and the write-only pins
 */

module lcd_assert #(
    parameter int unsigned EN_HIGH = 25
) (
    input logic       clk,
    input logic       rst_n,
    input logic       LCD_EN,
    input logic       LCD_RS,
    input logic       LCD_RW,
    input logic [7:0] LCD_DATA,
    input logic       drv_busy
);

    logic [31:0] en_len; // Cycles EN has been high so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_len <= '0;
        end else if (LCD_EN) begin
            en_len <= en_len + 32'd1;
        end else begin
            en_len <= '0; // Restart for next pulse
        end
    end

    // ==================================================
    // Enable pulse and bus checks
    // ==================================================
    en_width_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(LCD_EN) |-> en_len == EN_HIGH)
        else $error("LCD_EN pulse width differs from EN_HIGH");

    en_max_a: assert property (@(posedge clk) disable iff (!rst_n)
        LCD_EN |-> en_len < EN_HIGH)
        else $error("LCD_EN high longer than EN_HIGH");

    bus_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        LCD_EN |-> $stable(LCD_RS) && $stable(LCD_DATA))
        else $error("LCD_RS or LCD_DATA moved while LCD_EN high");

    rw_low_a: assert property (@(posedge clk) disable iff (!rst_n) !LCD_RW)
        else $error("LCD_RW driven high");

    busy_a: assert property (@(posedge clk) disable iff (!rst_n)
        LCD_EN |-> drv_busy)
        else $error("drv_busy low during enable pulse");

endmodule

bind lcd_bus_driver lcd_assert #(.EN_HIGH(EN_HIGH)) u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .LCD_EN   (LCD_EN),
    .LCD_RS   (LCD_RS),
    .LCD_RW   (LCD_RW),
    .LCD_DATA (LCD_DATA),
    .drv_busy (drv_busy)
);

// ==== tb_lcd_top.sv ====
/*
 * Testbench for the character LCD controller
 * Random line updates, bus transaction monitor and a reference
 * model of the init list and two-line writes
 */

module tb_lcd_top;

    localparam int PWRUP_CYC   = 40;
    localparam int INIT_CMDS   = 8;    // Length of power-on list
    localparam int N_UPDATES   = 6;
    localparam int TIMEOUT_CYC = 5000; // Per wait loop
    localparam int STRAY_LIMIT = 30;   // Stray pulses only early in a write

    logic         clk;
    logic         rst_n;
    logic [127:0] line1_data;
    logic [127:0] line2_data;
    logic         update_display;
    logic         LCD_ON;
    logic         LCD_BLON;
    logic         LCD_EN;
    logic         LCD_RS;
    logic         LCD_RW;
    logic [7:0]   LCD_DATA;
    logic         ready;
    logic         busy;

    logic [8:0]  got_q[$]; // {RS, DATA} seen on the bus
    logic [8:0]  exp_q[$]; // {RS, DATA} from the model
    int          tx_count;
    int          accept_count;
    int          cyc_since_rst;
    logic        accept_prev;
    logic [31:0] rng;

    lcd_top #(
        .PWRUP_CYC     (PWRUP_CYC),
        .EN_SETUP      (2),
        .EN_HIGH       (3),
        .DLY_CMD_CYC   (6),
        .DLY_WAKE_CYC  (30),
        .DLY_CLEAR_CYC (20)
    ) uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13); // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [127:0] rand_line();
        logic [127:0] v;
        for (int i = 0; i < 4; i++) v[32*i +: 32] = next_rand();
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s did not happen in %0d cycles", what, TIMEOUT_CYC);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    endtask

    // Set-address 80 / C0, then 16 chars each, leftmost in the top byte
    task automatic push_expected_update(input logic [127:0] l1, input logic [127:0] l2);
        exp_q.push_back({1'b0, 8'h80});
        for (int i = 0; i < 16; i++) exp_q.push_back({1'b1, l1[127-8*i -: 8]});
        exp_q.push_back({1'b0, 8'hC0});
        for (int i = 0; i < 16; i++) exp_q.push_back({1'b1, l2[127-8*i -: 8]});
    endtask

    task automatic compare_queues(input string phase);
        check({phase, " transaction count"}, exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check($sformatf("%s LCD_RS/LCD_DATA #%0d", phase, i), 32'(exp_q[i]),
                  32'(got_q[i]));
        end
        exp_q.delete();
        got_q.delete();
    endtask

    // ==================================================
    // Bus monitor on falling EN, where the panel latches
    // ==================================================
    always @(negedge LCD_EN) begin
        if (rst_n === 1'b1) begin
            got_q.push_back({LCD_RS, LCD_DATA});
            tx_count++;
        end
    end

    // ==================================================
    // Per-cycle status checks and acceptance model
    // ==================================================
    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            cyc_since_rst <= 0;
            accept_prev   <= 1'b0;
        end else begin
            cyc_since_rst <= cyc_since_rst + 1;
            check("busy", 32'(!ready), 32'(busy));
            check("LCD_ON", 32'd1, 32'(LCD_ON));
            check("LCD_BLON", 32'd1, 32'(LCD_BLON));
            check("LCD_RW", 32'd0, 32'(LCD_RW)); // Write-only bus
            if (cyc_since_rst < PWRUP_CYC) check("LCD_EN", 32'd0, 32'(LCD_EN));
            if (tx_count < INIT_CMDS) check("ready", 32'd0, 32'(ready)); // Still in init
            if (accept_prev) check("ready", 32'd0, 32'(ready));
            accept_prev <= ready && update_display;
            if (ready && update_display) begin
                push_expected_update(line1_data, line2_data); // Lines of accept cycle
                accept_count++;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic wait_init_done();
        int n;
        n = 0;
        while (!ready) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_fail("end of initialization");
        end
    endtask

    // Scramble inputs and pulse update_display while the write runs
    task automatic wait_write_done(input int start_tx);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_fail("end of display write");
            line1_data <= rand_line();
            line2_data <= rand_line();
            if ((tx_count - start_tx) < STRAY_LIMIT && next_rand() % 4 == 0)
                update_display <= 1'b1;
            else
                update_display <= 1'b0;
        end while (!ready);
        update_display <= 1'b0;
    endtask

    initial begin
        int gap;
        int start_tx;
        rst_n          = 1'b0;
        update_display = 1'b0;
        line1_data     = '0;
        line2_data     = '0;
        rng            = 32'ha8c4_73f5;
        tx_count       = 0;
        accept_count   = 0;
        // Power-on list with RS low throughout
        exp_q.push_back({1'b0, 8'h30});
        exp_q.push_back({1'b0, 8'h30});
        exp_q.push_back({1'b0, 8'h30});
        exp_q.push_back({1'b0, 8'h38});
        exp_q.push_back({1'b0, 8'h08});
        exp_q.push_back({1'b0, 8'h01});
        exp_q.push_back({1'b0, 8'h06});
        exp_q.push_back({1'b0, 8'h0C});

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        wait_init_done();
        compare_queues("init");

        for (int u = 0; u < N_UPDATES; u++) begin
            gap = int'(next_rand() % 6);
            repeat (gap) begin
                @(posedge clk);
                line1_data <= rand_line();
                line2_data <= rand_line();
            end
            @(posedge clk);
            line1_data     <= rand_line();
            line2_data     <= rand_line();
            update_display <= 1'b1;       // Accepted since ready is high here
            @(posedge clk);
            update_display <= 1'b0;
            line1_data     <= rand_line(); // Must not reach the panel
            line2_data     <= rand_line();
            start_tx = tx_count;
            wait_write_done(start_tx);
            compare_queues($sformatf("update %0d", u));
            check("accepted updates", 32'(u + 1), 32'(accept_count));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== all.f ====
lcd_bus_pkg.sv
lcd_text_pkg.sv
lcd_text_buffer.sv
lcd_sequencer.sv
lcd_bus_driver.sv
lcd_top.sv
lcd_assert.sv
tb_lcd_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LCD controller testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_lcd_top --Mdir obj_dir -o sim_lcd
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_lcd > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
